// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the triangle framebuffer testbench with Verilator.
# Exits with a non-zero status unless the log holds the pass message.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_triangle_fb \
    --Mdir obj_dir -o tb_triangle_fb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_triangle_fb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: source/display_timings.sv
/* 640x480 raster generator, 800 clocks per line and 525 lines per frame
   hsync and vsync are active low; frame and line are decoded from the counters */
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module display_timings (
    input  wire logic clk_pix,
    input  wire logic reset,
    output gfx_pkg::coord_t sx,
    output gfx_pkg::coord_t sy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic frame,
    output logic line
);

    localparam int HS_START = `GFX_H_ACTIVE + `GFX_H_FRONT;
    localparam int HS_END   = HS_START + `GFX_H_SYNC;
    localparam int LINE_END = HS_END + `GFX_H_BACK - 1;     // 799

    localparam int VS_START  = `GFX_V_ACTIVE + `GFX_V_FRONT;
    localparam int VS_END    = VS_START + `GFX_V_SYNC;
    localparam int FRAME_END = VS_END + `GFX_V_BACK - 1;    // 524

    // raster counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= gfx_pkg::coord_t'(LINE_END);  // park at last position
            sy <= gfx_pkg::coord_t'(FRAME_END);
        end else if (sx == LINE_END) begin
            sx <= '0;
            if (sy == FRAME_END) begin
                sy <= '0;
            end else begin
                sy <= sy + 1'b1;
            end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync windows and active area
    always_comb begin
        hsync = !(sx >= HS_START && sx < HS_END);  // active low
        vsync = !(sy >= VS_START && sy < VS_END);
        de    = (sx < `GFX_H_ACTIVE) && (sy < `GFX_V_ACTIVE);
        frame = (sx == 0) && (sy == 0);
        line  = (sx == 0);
    end

endmodule

`default_nettype wire

// File: source/draw_line.sv
/* Bresenham line drawer for every octant, one pixel per clock
   line_start is only taken while idle; both endpoints are emitted */
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module draw_line (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic line_start,
    input  wire gfx_pkg::coord_t xa,
    input  wire gfx_pkg::coord_t ya,
    input  wire gfx_pkg::coord_t xb,
    input  wire gfx_pkg::coord_t yb,
    output gfx_pkg::coord_t x,
    output gfx_pkg::coord_t y,
    output logic drawing,
    output logic line_done
);

    localparam int EW = `GFX_CORDW + 2;  // error term width

    typedef enum logic {IDLE, DRAW} state_t;
    state_t state;

    gfx_pkg::coord_t x_end, y_end;
    logic signed [`GFX_CORDW:0] span_x, span_y;   // signed deltas of the inputs
    logic signed [`GFX_CORDW:0] abs_x, abs_y;
    logic signed [EW-1:0] dx, dy, err;
    logic signed [EW:0] e2;
    logic step_neg_x, step_neg_y;  // step direction per axis
    logic move_x, move_y, last;

    always_comb begin
        span_x  = xb - xa;
        span_y  = yb - ya;
        abs_x   = span_x[`GFX_CORDW] ? -span_x : span_x;
        abs_y   = span_y[`GFX_CORDW] ? -span_y : span_y;
        e2      = err <<< 1;
        move_x  = (e2 >= dy);
        move_y  = (e2 <= dx);
        last    = (x == x_end) && (y == y_end);
        drawing = (state == DRAW);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state     <= IDLE;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            case (state)
                IDLE: if (line_start) state <= DRAW;
                DRAW: begin
                    if (last) begin
                        state     <= IDLE;
                        line_done <= 1'b1;  // cycle after last pixel
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // position and error term
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && line_start) begin
            x          <= xa;
            y          <= ya;
            x_end      <= xb;
            y_end      <= yb;
            dx         <= abs_x;
            dy         <= -abs_y;
            err        <= abs_x - abs_y;
            step_neg_x <= span_x[`GFX_CORDW];
            step_neg_y <= span_y[`GFX_CORDW];
        end else if (state == DRAW && !last) begin
            if (move_x) begin
                x <= step_neg_x ? x - 1'b1 : x + 1'b1;
            end
            if (move_y) begin
                y <= step_neg_y ? y - 1'b1 : y + 1'b1;
            end
            err <= err + (move_x ? dy : '0) + (move_y ? dx : '0);
        end
    end

endmodule

`default_nettype wire

// File: source/draw_triangle.sv
/* triangle outline drawer, edges v0-v1, v1-v2, v2-v0 in turn
   commands arriving while busy are dropped; done comes once per accepted command */
`timescale 1ns/1ps
`default_nettype none

module draw_triangle (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic cmd_valid,
    input  wire gfx_pkg::coord_t x0,
    input  wire gfx_pkg::coord_t y0,
    input  wire gfx_pkg::coord_t x1,
    input  wire gfx_pkg::coord_t y1,
    input  wire gfx_pkg::coord_t x2,
    input  wire gfx_pkg::coord_t y2,
    input  wire gfx_pkg::cidx_t cidx,
    output gfx_pkg::coord_t x,
    output gfx_pkg::coord_t y,
    output logic we,
    output gfx_pkg::cidx_t pix_cidx,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {IDLE, LINE, WAIT_LINE, FINISH} state_t;
    state_t state;

    logic [1:0] side;  // current edge 0..2
    gfx_pkg::coord_t vx0, vy0, vx1, vy1, vx2, vy2;
    gfx_pkg::coord_t line_xa, line_ya, line_xb, line_yb;
    logic line_start, line_done, drawing;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= IDLE;
            side  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        state <= LINE;
                        side  <= '0;
                    end
                end
                LINE: state <= WAIT_LINE;
                WAIT_LINE: begin
                    if (line_done) begin
                        if (side == 2'd2) begin
                            state <= FINISH;
                        end else begin
                            side  <= side + 1'b1;
                            state <= LINE;
                        end
                    end
                end
                default: state <= IDLE;  // FINISH
            endcase
        end
    end

    // command capture
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && cmd_valid) begin
            vx0      <= x0;
            vy0      <= y0;
            vx1      <= x1;
            vy1      <= y1;
            vx2      <= x2;
            vy2      <= y2;
            pix_cidx <= cidx;
        end
    end

    always_comb begin
        case (side)
            2'd0: {line_xa, line_ya, line_xb, line_yb} = {vx0, vy0, vx1, vy1};
            2'd1: {line_xa, line_ya, line_xb, line_yb} = {vx1, vy1, vx2, vy2};
            default: {line_xa, line_ya, line_xb, line_yb} = {vx2, vy2, vx0, vy0};
        endcase
        line_start = (state == LINE);
        busy       = (state != IDLE);
        done       = (state == FINISH);
        we         = drawing;
    end

    draw_line line_inst (
        .clk_pix,
        .reset,
        .line_start,
        .xa(line_xa),
        .ya(line_ya),
        .xb(line_xb),
        .yb(line_yb),
        .x,
        .y,
        .drawing,
        .line_done
    );

endmodule

`default_nettype wire

// File: source/framebuffer.sv
/* 160x120 colour index memory, written by the drawer and read at raster position / 4
   colour is valid one clock after sx, sy, de; memory powers up cleared, never cleared later */
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module framebuffer (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic we,
    input  wire gfx_pkg::coord_t x,
    input  wire gfx_pkg::coord_t y,
    input  wire gfx_pkg::cidx_t cidx,
    input  wire gfx_pkg::coord_t sx,
    input  wire gfx_pkg::coord_t sy,
    input  wire logic de,
    output gfx_pkg::chan_t red,
    output gfx_pkg::chan_t green,
    output gfx_pkg::chan_t blue
);

    localparam int FB_W  = `GFX_FB_WIDTH;
    localparam int FB_H  = `GFX_FB_HEIGHT;
    localparam int DEPTH = FB_W * FB_H;
    localparam int ADDRW = $clog2(DEPTH);
    localparam int SHIFT = $clog2(`GFX_FB_SCALE);  // scale is a power of two

    gfx_pkg::cidx_t mem [DEPTH];
    logic [ADDRW-1:0] wr_addr, rd_addr;
    logic wr_ok;
    gfx_pkg::coord_t fb_rx, fb_ry;
    gfx_pkg::cidx_t rd_cidx;
    logic de_q;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_comb begin
        wr_ok   = we && x >= 0 && x < FB_W && y >= 0 && y < FB_H;  // drop clipped pixels
        wr_addr = ADDRW'(y * FB_W + x);
        fb_rx   = sx >>> SHIFT;
        fb_ry   = sy >>> SHIFT;
        rd_addr = ADDRW'(fb_ry * FB_W + fb_rx);
    end

    // write port
    always_ff @(posedge clk_pix) begin
        if (wr_ok) begin
            mem[wr_addr] <= cidx;
        end
    end

    // read port, only inside the active area
    always_ff @(posedge clk_pix) begin
        if (de) begin
            rd_cidx <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            de_q <= 1'b0;
        end else begin
            de_q <= de;  // matches the read latency
        end
    end

    always_comb begin
        if (de_q) begin
            red   = gfx_pkg::palette_red(rd_cidx);
            green = gfx_pkg::palette_green(rd_cidx);
            blue  = gfx_pkg::palette_blue(rd_cidx);
        end else begin
            red   = '0;  // blank outside active area
            green = '0;
            blue  = '0;
        end
    end

endmodule

`default_nettype wire

// File: source/gfx_pkg.sv
/* shared types and the fixed four-entry palette
   palette tables assume a 2-bit colour index and 4-bit channels */
`default_nettype none
`include "gfx_settings.svh"

package gfx_pkg;

    typedef logic signed [`GFX_CORDW-1:0] coord_t;
    typedef logic [`GFX_CIDXW-1:0] cidx_t;
    typedef logic [`GFX_CHANW-1:0] chan_t;

    // palette: 0 black, 1 orange, 2 green, 3 blue
    function automatic chan_t palette_red(cidx_t idx);
        case (idx)
            2'd1: return 4'hf;
            2'd2: return 4'h2;
            2'd3: return 4'h3;
            default: return 4'h0;
        endcase
    endfunction

    function automatic chan_t palette_green(cidx_t idx);
        case (idx)
            2'd1: return 4'h8;
            2'd2: return 4'hc;
            2'd3: return 4'h6;
            default: return 4'h0;
        endcase
    endfunction

    function automatic chan_t palette_blue(cidx_t idx);
        case (idx)
            2'd1: return 4'h0;
            2'd2: return 4'h3;
            2'd3: return 4'hf;
            default: return 4'h0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/gfx_settings.svh
/* video timing and framebuffer settings shared by the whole design
   scale must be a power of two and the scaled framebuffer must match the active area */
`ifndef GFX_SETTINGS_SVH
`define GFX_SETTINGS_SVH

`define GFX_CORDW      16   // signed coordinate width
`define GFX_CIDXW      2    // colour index width
`define GFX_CHANW      4    // colour channel width

`define GFX_FB_WIDTH   160
`define GFX_FB_HEIGHT  120
`define GFX_FB_SCALE   4    // screen pixels per fb pixel, each axis

`define GFX_H_ACTIVE   640
`define GFX_H_FRONT    16
`define GFX_H_SYNC     96
`define GFX_H_BACK     48

`define GFX_V_ACTIVE   480
`define GFX_V_FRONT    10
`define GFX_V_SYNC     2
`define GFX_V_BACK     33

`endif

// File: source/triangle_fb_top.sv
/* triangle outlines into a 160x120 framebuffer shown at 640x480, single clock domain
   sync and de leave one clock late so they line up with the colour outputs */
`timescale 1ns/1ps
`default_nettype none

module triangle_fb_top (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic cmd_valid,
    input  wire gfx_pkg::coord_t x0,
    input  wire gfx_pkg::coord_t y0,
    input  wire gfx_pkg::coord_t x1,
    input  wire gfx_pkg::coord_t y1,
    input  wire gfx_pkg::coord_t x2,
    input  wire gfx_pkg::coord_t y2,
    input  wire gfx_pkg::cidx_t cidx,
    output logic busy,
    output logic done,
    output logic hsync,
    output logic vsync,
    output logic de,
    output gfx_pkg::chan_t red,
    output gfx_pkg::chan_t green,
    output gfx_pkg::chan_t blue
);

    gfx_pkg::coord_t sx, sy;      // raster position
    gfx_pkg::coord_t fb_x, fb_y;  // drawer pixel
    gfx_pkg::cidx_t fb_cidx;
    logic hsync_raw, vsync_raw, de_raw;
    logic fb_we;

    display_timings timings_inst (
        .clk_pix,
        .reset,
        .sx,
        .sy,
        .hsync(hsync_raw),
        .vsync(vsync_raw),
        .de(de_raw),
        .frame(),
        .line()
    );

    draw_triangle triangle_inst (
        .clk_pix,
        .reset,
        .cmd_valid,
        .x0, .y0, .x1, .y1, .x2, .y2,
        .cidx,
        .x(fb_x),
        .y(fb_y),
        .we(fb_we),
        .pix_cidx(fb_cidx),
        .busy,
        .done
    );

    framebuffer fb_inst (
        .clk_pix,
        .reset,
        .we(fb_we),
        .x(fb_x),
        .y(fb_y),
        .cidx(fb_cidx),
        .sx,
        .sy,
        .de(de_raw),
        .red,
        .green,
        .blue
    );

    // one clock delay to match the framebuffer read
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
        end else begin
            hsync <= hsync_raw;
            vsync <= vsync_raw;
            de    <= de_raw;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_triangle_fb.sv
/* testbench for triangle_fb_top, records come from verification/triangle_patterns.txt
   a probe of fb pixel x, y is sampled at screen column scale*x+1 and row scale*y+1 */
`timescale 1ns/1ps
`default_nettype none
`include "gfx_settings.svh"

module tb_triangle_fb;

    localparam int SCALE = `GFX_FB_SCALE;
    localparam int LINE_CLKS = `GFX_H_ACTIVE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK;
    localparam int FRAME_LINES = `GFX_V_ACTIVE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK;
    localparam int FRAME_CLKS = LINE_CLKS * FRAME_LINES;  // 420000
    localparam int DONE_TIMEOUT = 2000;
    localparam int PROBE_TIMEOUT = 2 * FRAME_CLKS + 1000;
    localparam int NREC = 64;

    logic clk_pix, reset, cmd_valid;
    gfx_pkg::coord_t x0, y0, x1, y1, x2, y2;
    gfx_pkg::cidx_t cidx;
    logic busy, done, hsync, vsync, de;
    gfx_pkg::chan_t red, green, blue;

    logic [15:0] pat [NREC*8];
    int errors, checks, dones_seen, dones_expected;
    logic timed_out;

    // screen tracking, owned by the monitor
    logic frame_seen, de_prev, vsync_prev, hsync_prev;
    int de_cols, de_rows, frame_clks, col, hs_low;
    logic probe_armed, probe_hit;
    int probe_row, probe_col;
    gfx_pkg::chan_t probe_r, probe_g, probe_b;

    triangle_fb_top UUT (
        .clk_pix, .reset, .cmd_valid,
        .x0, .y0, .x1, .y1, .x2, .y2, .cidx,
        .busy, .done, .hsync, .vsync, .de,
        .red, .green, .blue
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    task automatic report_error(string msg);
        errors++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d, done pulses: %0d", checks, errors, dones_seen);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(string msg);
        $display("timeout: %s", msg);
        timed_out = 1'b1;
    endtask

    // outputs sampled at the falling edge
    always @(negedge clk_pix) begin
        if (reset) begin
            frame_seen = 1'b0;
            de_prev    = 1'b0;
            vsync_prev = 1'b1;
            hsync_prev = 1'b1;
            de_cols    = 0;
            de_rows    = 0;
            frame_clks = 0;
            hs_low     = 0;
        end else begin
            frame_clks++;
            if (done) dones_seen++;
            if (!de) begin
                checks++;
                assert ({red, green, blue} == '0)
                else report_error($sformatf("colour %h%h%h while de low", red, green, blue));
            end
            if (!hsync) hs_low++;
            if (!hsync_prev && hsync) begin
                checks++;
                assert (hs_low == `GFX_H_SYNC)
                else report_error($sformatf("hsync pulse lasted %0d clocks", hs_low));
                hs_low = 0;
            end
            if (de_prev && !de) begin
                checks++;
                assert (de_cols == `GFX_H_ACTIVE)
                else report_error($sformatf("line had %0d de cycles", de_cols));
            end
            if (vsync_prev && !vsync) begin
                if (frame_seen) begin  // a whole frame lies behind us
                    checks += 2;
                    assert (frame_clks == FRAME_CLKS)
                    else report_error($sformatf("frame took %0d clocks", frame_clks));
                    assert (de_rows == `GFX_V_ACTIVE)
                    else report_error($sformatf("frame had %0d de lines", de_rows));
                end
                frame_seen = 1'b1;
                frame_clks = 0;
                de_rows    = 0;
            end
            if (de) begin
                if (!de_prev) begin
                    de_rows++;
                    de_cols = 0;
                end
                col = de_cols;
                de_cols++;
                if (frame_seen && probe_armed && !probe_hit &&
                    de_rows - 1 == probe_row && col == probe_col) begin
                    probe_r   = red;
                    probe_g   = green;
                    probe_b   = blue;
                    probe_hit = 1'b1;
                end
            end
            de_prev    = de;
            vsync_prev = vsync;
            hsync_prev = hsync;
        end
    end

    task automatic send_command(int base);
        x0 = pat[base+1];
        y0 = pat[base+2];
        x1 = pat[base+3];
        y1 = pat[base+4];
        x2 = pat[base+5];
        y2 = pat[base+6];
        cidx = pat[base+7][1:0];
        cmd_valid = 1'b1;
        @(posedge clk_pix);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        logic got;
        n = 0;
        got = 1'b0;
        while (!got && n < DONE_TIMEOUT) begin
            @(negedge clk_pix);
            got = done;
            n++;
        end
        @(posedge clk_pix);
        #1;
        if (!got) report_timeout("no done strobe after a triangle command");
    endtask

    task automatic probe_pixel(int base);
        int fx, fy, n;
        gfx_pkg::chan_t er, eg, eb;
        fx = int'(pat[base+1]);
        fy = int'(pat[base+2]);
        er = pat[base+3][3:0];
        eg = pat[base+4][3:0];
        eb = pat[base+5][3:0];
        probe_row   = SCALE * fy + 1;
        probe_col   = SCALE * fx + 1;
        probe_hit   = 1'b0;
        probe_armed = 1'b1;
        n = 0;
        while (!probe_hit && n < PROBE_TIMEOUT) begin
            @(posedge clk_pix);
            n++;
        end
        #1;
        probe_armed = 1'b0;
        if (!probe_hit) begin
            report_timeout($sformatf("screen never reached pixel %0d,%0d", fx, fy));
        end else begin
            checks++;
            assert ({probe_r, probe_g, probe_b} == {er, eg, eb})
            else report_error($sformatf("pixel %0d,%0d is %h%h%h, expected %h%h%h",
                                        fx, fy, probe_r, probe_g, probe_b, er, eg, eb));
        end
    endtask

    initial begin
        int kind, base;
        errors = 0;
        checks = 0;
        dones_seen = 0;
        dones_expected = 0;
        timed_out = 1'b0;
        probe_armed = 1'b0;
        probe_hit = 1'b0;
        probe_row = 0;
        probe_col = 0;
        reset = 1'b1;
        cmd_valid = 1'b0;
        {x0, y0, x1, y1, x2, y2} = '0;
        cidx = '0;
        for (int i = 0; i < NREC * 8; i++) begin
            pat[i] = '0;
        end
        $readmemh("verification/triangle_patterns.txt", pat);

        repeat (8) @(posedge clk_pix);
        #1;
        checks++;
        assert (!busy && !done && hsync && vsync && !de)
        else report_error("outputs not idle during reset");
        reset = 1'b0;

        for (int rec = 0; rec < NREC && !timed_out; rec++) begin
            base = rec * 8;
            kind = int'(pat[base]);
            if (kind == 0) break;
            case (kind)
                1: begin
                    send_command(base);
                    dones_expected++;
                    wait_done();
                end
                2: begin
                    send_command(base);
                    dones_expected++;
                end
                3: begin
                    checks++;
                    assert (busy) else report_error("busy low before the dropped command");
                    send_command(base);
                    wait_done();
                    if (!timed_out) begin
                        repeat (DONE_TIMEOUT) @(posedge clk_pix);  // quiet window for a stray done
                        #1;
                        checks++;
                        assert (dones_seen == dones_expected)
                        else report_error($sformatf("%0d done pulses, expected %0d",
                                                    dones_seen, dones_expected));
                    end
                end
                4: probe_pixel(base);
                default: begin
                    errors++;
                    $display("pattern file holds an unknown record kind %0d", kind);
                end
            endcase
        end

        if (!timed_out) begin
            checks++;
            assert (dones_seen == dones_expected)
            else report_error($sformatf("%0d done pulses, expected %0d",
                                        dones_seen, dones_expected));
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: verification/triangle_patterns.txt
// command: kind x0 y0 x1 y1 x2 y2 cidx (1 draw and wait, 2 draw, 3 strobe while busy)
// probe: 0004 fb_x fb_y red green blue 0000 0000; kind 0000 ends the list
0004 0014 0014 0000 0000 0000 0000 0000 // nothing drawn yet
0004 0064 0050 0000 0000 0000 0000 0000
0001 0014 0014 003c 0014 0014 003c 0001 // A orange
0004 0014 0014 000f 0008 0000 0000 0000
0004 0028 0014 000f 0008 0000 0000 0000
0004 003c 0014 000f 0008 0000 0000 0000
0004 001e 001e 0000 0000 0000 0000 0000 // inside A
0004 0014 0028 000f 0008 0000 0000 0000
0004 0014 003c 000f 0008 0000 0000 0000
0001 0014 0014 003c 0014 003c 003c 0002 // B green, shares top edge
0004 0028 0014 0002 000c 0003 0000 0000
0004 003c 0014 0002 000c 0003 0000 0000
0004 0014 0028 000f 0008 0000 0000 0000
0004 003c 0028 0002 000c 0003 0000 0000
0002 0050 0050 0078 0050 0050 006e 0003 // C blue
0003 0064 000a 008c 000a 008c 0028 0001 // D dropped
0004 0064 000a 0000 0000 0000 0000 0000
0004 008c 0028 0000 0000 0000 0000 0000
0004 0050 0050 0003 0006 000f 0000 0000
0004 0078 0050 0003 0006 000f 0000 0000
0004 0050 005f 0003 0006 000f 0000 0000
0004 0050 006e 0003 0006 000f 0000 0000
0001 0082 0064 00c8 0064 0082 008c 0002 // E green, partly off screen
0004 0082 0064 0002 000c 0003 0000 0000
0004 009f 0064 0002 000c 0003 0000 0000
0004 0091 006e 0000 0000 0000 0000 0000
0004 0082 0077 0002 000c 0003 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000

// File: vlog.f
+incdir+source
source/gfx_pkg.sv
source/display_timings.sv
source/draw_line.sv
source/draw_triangle.sv
source/framebuffer.sv
source/triangle_fb_top.sv
verification/tb_triangle_fb.sv
